// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register file
`define CPU_XLEN 32
`define CPU_REG_ADDR_W 5
`define CPU_REG_COUNT 32

// Shift-add multiplier
`define CPU_MUL_STEPS 32
`define CPU_STEP_W 6

`endif

// ==== cpuPkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpuPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatFields;

    typedef struct packed {
        logic [5:0] opcode;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [15:0] imm;
    } iFormatFields;

    // Same 32 bits, two views
    typedef union packed {
        rFormatFields rFormat;
        iFormatFields iFormat;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        passHi,
        passLo,
        passImm
    } aluOp;

    typedef struct packed {
        logic [`CPU_REG_ADDR_W-1:0] srcA;
        logic [`CPU_REG_ADDR_W-1:0] srcB;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic useImm;
        logic writesReg;
        logic isMul;
        aluOp alu;
        logic [`CPU_XLEN-1:0] imm;
    } decodedOp;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
    } mulRequest;

    typedef struct packed {
        logic valid;
        logic [`CPU_REG_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0] data;
    } wbBundle;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module instrDecoder (
    input  cpuPkg::instrWord instr,
    output cpuPkg::decodedOp op
);

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;

    localparam logic [5:0] fnMfhi = 6'h10;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    always_comb begin
        op = '0;
        op.alu = cpuPkg::aluAdd;
        op.srcA = instr.rFormat.rs;
        op.writesReg = 1'b1;
        if (instr.rFormat.opcode == opSpecial) begin
            op.srcB = instr.rFormat.rt;
            op.dest = instr.rFormat.rd;
            case (instr.rFormat.funct)
                fnAddu: op.alu = cpuPkg::aluAdd;
                fnSubu: op.alu = cpuPkg::aluSub;
                fnAnd: op.alu = cpuPkg::aluAnd;
                fnOr: op.alu = cpuPkg::aluOr;
                fnXor: op.alu = cpuPkg::aluXor;
                fnSlt: op.alu = cpuPkg::aluSlt;
                fnSltu: op.alu = cpuPkg::aluSltu;
                fnMultu: begin
                    op.isMul = 1'b1;
                    op.writesReg = 1'b0;
                end
                fnMfhi: begin
                    op.alu = cpuPkg::passHi;
                    op.srcA = '0;
                end
                fnMflo: begin
                    op.alu = cpuPkg::passLo;
                    op.srcA = '0;
                end
                default: op.writesReg = 1'b0;
            endcase
        end else begin
            op.dest = instr.iFormat.rt;
            op.useImm = 1'b1;
            case (instr.iFormat.opcode)
                opAddiu: begin
                    op.imm = {{(`CPU_XLEN-16){instr.iFormat.imm[15]}}, instr.iFormat.imm};
                end
                opAndi: begin
                    op.alu = cpuPkg::aluAnd;
                    op.imm = {{(`CPU_XLEN-16){1'b0}}, instr.iFormat.imm};
                end
                opOri: begin
                    op.alu = cpuPkg::aluOr;
                    op.imm = {{(`CPU_XLEN-16){1'b0}}, instr.iFormat.imm};
                end
                opLui: begin
                    op.alu = cpuPkg::passImm;
                    op.srcA = '0;
                    op.imm = {instr.iFormat.imm, {(`CPU_XLEN-16){1'b0}}};
                end
                default: op.writesReg = 1'b0;
            endcase
        end
        // Register zero is never written
        if (op.dest == '0) begin
            op.writesReg = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module regFile (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic [`CPU_REG_ADDR_W-1:0] readAddrA,
    input  wire logic [`CPU_REG_ADDR_W-1:0] readAddrB,
    output logic [`CPU_XLEN-1:0] readDataA,
    output logic [`CPU_XLEN-1:0] readDataB,
    input  cpuPkg::wbBundle wb
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // No write-through, the core forwards the writeback value
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== mulSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulSequencer (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic start,
    input  wire logic last,
    output logic busy,
    output logic load,
    output logic step
);

    typedef enum logic {
        seqIdle,
        seqRun
    } seqState;

    seqState state;
    seqState nextState;

    always_comb begin
        nextState = state;
        case (state)
            seqIdle: if (start) nextState = seqRun;
            seqRun: if (last) nextState = seqIdle;
            default: nextState = seqIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seqIdle;
        end else begin
            state <= nextState;
        end
    end

    assign busy = (state == seqRun);
    assign load = (state == seqIdle) && start;
    assign step = (state == seqRun);

endmodule

`default_nettype wire

// ==== stepCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module stepCounter (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic load,
    input  wire logic step,
    output logic last
);

    logic [`CPU_STEP_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= `CPU_STEP_W'(`CPU_MUL_STEPS - 1);
        end else if (step && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign last = (count == '0);

endmodule

`default_nettype wire

// ==== mulDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module mulDatapath (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic load,
    input  wire logic step,
    input  cpuPkg::mulRequest req,
    output logic [`CPU_XLEN-1:0] hi,
    output logic [`CPU_XLEN-1:0] lo
);

    logic [`CPU_XLEN-1:0] multiplicand;
    logic [`CPU_XLEN:0] partial;

    // Carry out of the add lands in the top bit before the shift
    assign partial = {1'b0, hi} + (lo[0] ? {1'b0, multiplicand} : '0);

    always_ff @(posedge clk) begin
        if (load) begin
            multiplicand <= req.a;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (load) begin
            hi <= '0;
            lo <= req.b;
        end else if (step) begin
            hi <= partial[`CPU_XLEN:1];
            lo <= {partial[0], lo[`CPU_XLEN-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== pipeCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module pipeCore (
    input  wire logic clk,
    input  wire logic reset,
    input  cpuPkg::instrWord instr,
    input  wire logic instrValid,
    output logic instrReady,
    output logic [`CPU_REG_ADDR_W-1:0] readAddrA,
    output logic [`CPU_REG_ADDR_W-1:0] readAddrB,
    input  wire logic [`CPU_XLEN-1:0] readDataA,
    input  wire logic [`CPU_XLEN-1:0] readDataB,
    input  wire logic mulBusy,
    output logic mulStart,
    output cpuPkg::mulRequest mulReq,
    input  wire logic [`CPU_XLEN-1:0] hi,
    input  wire logic [`CPU_XLEN-1:0] lo,
    output cpuPkg::wbBundle wb
);

    cpuPkg::decodedOp decOp;
    cpuPkg::decodedOp exeOp;
    cpuPkg::wbBundle wbReg;
    logic exeValid;
    logic exeWrites;
    logic [`CPU_XLEN-1:0] exeA;
    logic [`CPU_XLEN-1:0] exeB;
    logic [`CPU_XLEN-1:0] operandB;
    logic [`CPU_XLEN-1:0] exeResult;
    logic [`CPU_XLEN-1:0] fwdA;
    logic [`CPU_XLEN-1:0] fwdB;
    logic needsMul;
    logic accept;

    // Execute result first, then writeback, then register file
    function automatic logic [`CPU_XLEN-1:0] forwardOperand(
        input logic [`CPU_REG_ADDR_W-1:0] addr,
        input logic [`CPU_XLEN-1:0] rfData,
        input logic exeHit,
        input logic [`CPU_REG_ADDR_W-1:0] exeAddr,
        input logic [`CPU_XLEN-1:0] exeData,
        input cpuPkg::wbBundle wbSrc
    );
        if (addr == '0) begin
            return rfData;
        end else if (exeHit && exeAddr == addr) begin
            return exeData;
        end else if (wbSrc.valid && wbSrc.addr == addr) begin
            return wbSrc.data;
        end
        return rfData;
    endfunction

    instrDecoder u_decoder (
        .instr(instr),
        .op(decOp)
    );

    assign readAddrA = decOp.srcA;
    assign readAddrB = decOp.srcB;
    assign exeWrites = exeValid && exeOp.writesReg;

    assign fwdA = forwardOperand(decOp.srcA, readDataA, exeWrites, exeOp.dest, exeResult, wbReg);
    assign fwdB = forwardOperand(decOp.srcB, readDataB, exeWrites, exeOp.dest, exeResult, wbReg);

    // HI/LO users wait for the multiplier
    assign needsMul = decOp.isMul || decOp.alu == cpuPkg::passHi || decOp.alu == cpuPkg::passLo;
    assign instrReady = !(needsMul && mulBusy);
    assign accept = instrValid && instrReady;

    assign mulStart = accept && decOp.isMul;
    assign mulReq.a = fwdA;
    assign mulReq.b = fwdB;

    always_ff @(posedge clk) begin
        if (reset) begin
            exeValid <= 1'b0;
        end else begin
            exeValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exeOp <= decOp;
            exeA <= fwdA;
            exeB <= fwdB;
        end
    end

    assign operandB = exeOp.useImm ? exeOp.imm : exeB;

    always_comb begin
        exeResult = '0;
        case (exeOp.alu)
            cpuPkg::aluAdd: exeResult = exeA + operandB;
            cpuPkg::aluSub: exeResult = exeA - operandB;
            cpuPkg::aluAnd: exeResult = exeA & operandB;
            cpuPkg::aluOr: exeResult = exeA | operandB;
            cpuPkg::aluXor: exeResult = exeA ^ operandB;
            cpuPkg::aluSlt: exeResult[0] = $signed(exeA) < $signed(operandB);
            cpuPkg::aluSltu: exeResult[0] = exeA < operandB;
            cpuPkg::passHi: exeResult = hi;
            cpuPkg::passLo: exeResult = lo;
            cpuPkg::passImm: exeResult = exeOp.imm;
            default: exeResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbReg.valid <= 1'b0;
        end else begin
            wbReg.valid <= exeWrites;
        end
        wbReg.addr <= exeOp.dest;
        wbReg.data <= exeResult;
    end

    assign wb = wbReg;

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuTop (
    input  wire logic clk,
    input  wire logic reset,
    input  cpuPkg::instrWord instr,
    input  wire logic instrValid,
    output logic instrReady,
    output cpuPkg::wbBundle wb
);

    logic [`CPU_REG_ADDR_W-1:0] readAddrA;
    logic [`CPU_REG_ADDR_W-1:0] readAddrB;
    logic [`CPU_XLEN-1:0] readDataA;
    logic [`CPU_XLEN-1:0] readDataB;
    logic [`CPU_XLEN-1:0] hi;
    logic [`CPU_XLEN-1:0] lo;
    cpuPkg::mulRequest mulReq;
    logic mulBusy;
    logic mulStart;
    logic mulLoad;
    logic mulStep;
    logic mulLast;

    pipeCore u_core (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .mulBusy(mulBusy),
        .mulStart(mulStart),
        .mulReq(mulReq),
        .hi(hi),
        .lo(lo),
        .wb(wb)
    );

    regFile u_regs (
        .clk(clk),
        .reset(reset),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .wb(wb)
    );

    mulSequencer u_mulSeq (
        .clk(clk),
        .reset(reset),
        .start(mulStart),
        .last(mulLast),
        .busy(mulBusy),
        .load(mulLoad),
        .step(mulStep)
    );

    stepCounter u_mulCount (
        .clk(clk),
        .reset(reset),
        .load(mulLoad),
        .step(mulStep),
        .last(mulLast)
    );

    mulDatapath u_mulData (
        .clk(clk),
        .reset(reset),
        .load(mulLoad),
        .step(mulStep),
        .req(mulReq),
        .hi(hi),
        .lo(lo)
    );

endmodule

`default_nettype wire

// ==== tbCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tbCpu;

    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] fnMfhi = 6'h10;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    localparam int numRandom = 48;
    localparam int numChain = 24;
    localparam int mulRounds = 3;
    localparam int totalInstr = numRandom + (numChain + 5) + 8 + mulRounds * 9
        + mulRounds * (mulRounds - 1) / 2 + 6;
    localparam int timeoutCycles = totalInstr * (`CPU_MUL_STEPS + 4) + 100;

    typedef struct packed {
        logic [`CPU_REG_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0] data;
        logic [31:0] dueEdge;
    } expectedWrite;

    logic clk;
    logic reset;
    cpuPkg::instrWord instr;
    logic instrValid;
    logic instrReady;
    cpuPkg::wbBundle wb;

    logic [`CPU_XLEN-1:0] modelRegs [`CPU_REG_COUNT];
    logic [`CPU_XLEN-1:0] modelHi;
    logic [`CPU_XLEN-1:0] modelLo;
    expectedWrite expQ[$];
    logic [31:0] rngState;
    logic [31:0] edgeCount;
    int cycleCount;
    int errCount;
    int testErrBase;
    int passCount;
    int failCount;
    int lastStalls;

    cpuTop u_dut (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .wb(wb)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [4:0] randomReg();
        return 5'(1 + nextRandom() % 31);
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] opcode, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pickFunct(input int sel);
        case (sel)
            0: return fnAddu;
            1: return fnSubu;
            2: return fnAnd;
            3: return fnOr;
            4: return fnXor;
            5: return fnSlt;
            default: return fnSltu;
        endcase
    endfunction

    function automatic logic [31:0] randomAluInstr();
        int sel;
        logic [31:0] bits;
        sel = int'(nextRandom() % 11);
        bits = nextRandom();
        if (sel < 7) begin
            return encodeR(pickFunct(sel), bits[4:0], bits[9:5], bits[14:10]);
        end
        case (sel)
            7: return encodeI(opAddiu, bits[4:0], bits[9:5], bits[31:16]);
            8: return encodeI(opAndi, bits[4:0], bits[9:5], bits[31:16]);
            9: return encodeI(opOri, bits[4:0], bits[9:5], bits[31:16]);
            default: return encodeI(opLui, bits[4:0], bits[9:5], bits[31:16]);
        endcase
    endfunction

    // Executes one instruction at a time in program order
    function automatic cpuPkg::wbBundle executeRef(input logic [31:0] word);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        logic [2*`CPU_XLEN-1:0] product;
        cpuPkg::wbBundle res;
        rs = word[25:21];
        rt = word[20:16];
        imm = word[15:0];
        a = modelRegs[rs];
        b = modelRegs[rt];
        res = '0;
        res.valid = 1'b1;
        if (word[31:26] == 6'h00) begin
            res.addr = word[15:11];
            case (word[5:0])
                fnAddu: res.data = a + b;
                fnSubu: res.data = a - b;
                fnAnd: res.data = a & b;
                fnOr: res.data = a | b;
                fnXor: res.data = a ^ b;
                fnSlt: res.data = {31'd0, $signed(a) < $signed(b)};
                fnSltu: res.data = {31'd0, a < b};
                fnMfhi: res.data = modelHi;
                fnMflo: res.data = modelLo;
                fnMultu: begin
                    product = {32'd0, a} * {32'd0, b};
                    modelHi = product[63:32];
                    modelLo = product[31:0];
                    res.valid = 1'b0;
                end
                default: res.valid = 1'b0;
            endcase
        end else begin
            res.addr = rt;
            case (word[31:26])
                opAddiu: res.data = a + {{16{imm[15]}}, imm};
                opAndi: res.data = a & {16'd0, imm};
                opOri: res.data = a | {16'd0, imm};
                opLui: res.data = {imm, 16'd0};
                default: res.valid = 1'b0;
            endcase
        end
        if (res.addr == '0) begin
            res.valid = 1'b0;
        end
        if (res.valid) begin
            modelRegs[res.addr] = res.data;
        end
        return res;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %h expected %h", $time, name, actual, expected);
            errCount++;
        end
    endtask

    // Offer one word and hold it until accepted
    task automatic issue(input logic [31:0] word);
        logic taken;
        lastStalls = 0;
        taken = 1'b0;
        instr <= word;
        instrValid <= 1'b1;
        while (!taken) begin
            @(posedge clk);
            taken = instrReady;
            if (!taken) begin
                lastStalls++;
            end
        end
        instrValid <= 1'b0;
    endtask

    task automatic endTest(input string name);
        int waited;
        int errs;
        waited = 0;
        while (expQ.size() != 0 && waited < `CPU_MUL_STEPS + 8) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            $display("%s: %0d expected writebacks never appeared", name, expQ.size());
            errCount++;
            expQ.delete();
        end
        repeat (2) @(posedge clk);
        errs = errCount - testErrBase;
        if (errs == 0) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: %0d errors", name, errs);
            failCount++;
        end
        testErrBase = errCount;
    endtask

    // Acceptances feed the model and writebacks are compared in order
    always @(posedge clk) begin : monitor
        expectedWrite entry;
        cpuPkg::wbBundle result;
        if (!reset) begin
            if (wb.valid) begin
                if (expQ.size() == 0) begin
                    $display("%0t: write to register %0d appeared with none expected",
                             $time, wb.addr);
                    errCount++;
                end else begin
                    entry = expQ.pop_front();
                    checkValue("wb.addr", 32'(wb.addr), 32'(entry.addr));
                    checkValue("wb.data", wb.data, entry.data);
                    checkValue("wb edge", edgeCount, entry.dueEdge);
                end
            end
            if (instrValid && instrReady) begin
                result = executeRef(instr);
                if (result.valid) begin
                    entry.addr = result.addr;
                    entry.data = result.data;
                    entry.dueEdge = edgeCount + 2;
                    expQ.push_back(entry);
                end
            end
        end
        edgeCount = edgeCount + 1;
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0] prevA;
        logic [4:0] prevB;
        logic [4:0] dest;
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        instrValid = 1'b0;
        rngState = 32'd61423;
        edgeCount = '0;
        errCount = 0;
        testErrBase = 0;
        passCount = 0;
        failCount = 0;
        lastStalls = 0;
        modelHi = '0;
        modelLo = '0;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Idle levels after reset
        repeat (3) begin
            @(posedge clk);
            if (wb.valid !== 1'b0 || instrReady !== 1'b1) begin
                $display("After reset wb.valid is not low or instrReady is not high");
                errCount++;
            end
        end
        for (int i = 0; i < numRandom; i++) begin
            issue(randomAluInstr());
        end
        endTest("aluRandom");

        // rs from execute, rt from writeback
        issue(encodeI(opAddiu, 5'd0, 5'd1, 16'(nextRandom())));
        issue(encodeI(opAddiu, 5'd0, 5'd2, 16'(nextRandom())));
        prevA = 5'd2;
        prevB = 5'd1;
        for (int i = 0; i < numChain; i++) begin
            dest = randomReg();
            issue(encodeR(pickFunct(int'(nextRandom() % 7)), prevA, prevB, dest));
            prevB = prevA;
            prevA = dest;
        end
        issue(encodeI(opOri, 5'd0, 5'd20, 16'h5a5a));
        issue(encodeI(opAddiu, 5'd0, 5'd21, 16'h0003));
        issue(encodeR(fnAddu, 5'd20, 5'd20, 5'd22));
        endTest("forwarding");

        issue(encodeI(opOri, 5'd0, 5'd0, 16'h1234));
        issue(encodeR(fnAddu, 5'd0, 5'd0, 5'd3));
        issue(encodeR(fnAddu, 5'd1, 5'd2, 5'd0));
        issue(encodeR(fnOr, 5'd0, 5'd1, 5'd4));
        issue(encodeI(opAddiu, 5'd5, 5'd0, 16'h7fff));
        issue(encodeI(opLui, 5'd0, 5'd0, 16'hbeef));
        issue(encodeR(fnSltu, 5'd0, 5'd1, 5'd6));
        issue(encodeI(opAddiu, 5'd0, 5'd7, 16'h0000));
        endTest("regZero");

        for (int round = 0; round < mulRounds; round++) begin
            a = nextRandom();
            b = nextRandom();
            if (round == 0) begin
                a = '1;
                b = '1;
            end
            issue(encodeI(opLui, 5'd0, 5'd11, a[31:16]));
            issue(encodeI(opOri, 5'd11, 5'd11, a[15:0]));
            issue(encodeI(opLui, 5'd0, 5'd12, b[31:16]));
            issue(encodeI(opOri, 5'd12, 5'd12, b[15:0]));
            issue(encodeR(fnMultu, 5'd11, 5'd12, 5'd0));
            for (int k = 0; k <= round; k++) begin
                issue(encodeI(opAddiu, randomReg(), randomReg(), 16'(nextRandom())));
                if (lastStalls != 0) begin
                    $display("ALU instruction was held back during a multiply");
                    errCount++;
                end
            end
            issue(encodeR(fnMfhi, 5'd0, 5'd0, 5'd13));
            checkValue("mfhi stall cycles", lastStalls, `CPU_MUL_STEPS - (round + 1));
            issue(encodeR(fnMflo, 5'd0, 5'd0, 5'd14));
            checkValue("mflo stall cycles", lastStalls, 0);
            issue(encodeR(fnAddu, 5'd13, 5'd14, 5'd15));
        end
        endTest("multiply");

        // Back-to-back work right after a full stall
        issue(encodeR(fnMultu, 5'd13, 5'd14, 5'd0));
        issue(encodeR(fnMflo, 5'd0, 5'd0, 5'd16));
        checkValue("mflo stall cycles", lastStalls, `CPU_MUL_STEPS);
        issue(encodeR(fnAddu, 5'd16, 5'd16, 5'd17));
        issue(encodeR(fnMfhi, 5'd0, 5'd0, 5'd18));
        checkValue("mfhi stall cycles", lastStalls, 0);
        issue(encodeR(fnSubu, 5'd18, 5'd17, 5'd19));
        issue(encodeR(fnXor, 5'd19, 5'd16, 5'd20));
        endTest("stallTiming");

        $display("Tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
cpuPkg.sv
instrDecoder.sv
regFile.sv
mulSequencer.sv
stepCounter.sv
mulDatapath.sv
pipeCore.sv
cpuTop.sv
tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu_pipe

export_include_dirs:
  - .

sources:
  - cpuPkg.sv
  - instrDecoder.sv
  - regFile.sv
  - mulSequencer.sv
  - stepCounter.sv
  - mulDatapath.sv
  - pipeCore.sv
  - cpuTop.sv
  - target: test
    files:
      - tbCpu.sv
